/* Bender.yml */
package:
  name: calc

sources:
  - files:
      - hdl/calc_pkg.sv
      - hdl/key_entry.sv
      - hdl/addsub_unit.sv
      - hdl/shift_add_multiplier.sv
      - hdl/calc_controller.sv
      - hdl/calc_top.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/calc_top_tb.sv

/* calc.f */
hdl/calc_pkg.sv
hdl/key_entry.sv
hdl/addsub_unit.sv
hdl/shift_add_multiplier.sv
hdl/calc_controller.sv
hdl/calc_top.sv
tests/tb_clock_gen.sv
tests/calc_top_tb.sv

/* hdl/addsub_unit.sv */
module addsub_unit #(
    parameter int DATA_WIDTH = 16
) (
    input  logic                  clk,
    input  logic                  nRST,
    input  logic                  start,                 // Ignored while busy
    input  logic                  sub,                   // 1 selects a - b
    input  logic [DATA_WIDTH-1:0] in_a,
    input  logic [DATA_WIDTH-1:0] in_b,
    output logic [DATA_WIDTH-1:0] result,
    output logic                  finish                 // One cycle, result valid
);
    localparam int CNT_W = (DATA_WIDTH > 1) ? $clog2(DATA_WIDTH) : 1;

    logic                  busy;
    logic [CNT_W-1:0]      bit_cnt;                      // Index of bit in flight
    logic                  load;                         // Accepted start
    logic                  last_bit;
    logic [DATA_WIDTH-1:0] a_sh;                         // Remaining bits of a
    logic [DATA_WIDTH-1:0] b_sh;                         // Remaining bits of b, inverted on sub
    logic [DATA_WIDTH-1:0] b_eff;
    logic                  carry;
    logic                  a_bit;
    logic                  b_bit;
    logic                  c_in;
    logic                  sum_bit;
    logic                  c_out;

    assign load     = start && !busy;
    assign last_bit = (bit_cnt == CNT_W'(DATA_WIDTH - 1));
    assign b_eff    = sub ? ~in_b : in_b;                // Two's complement with carry-in 1

    // Bit 0 is summed on the start edge straight from the inputs
    assign a_bit   = busy ? a_sh[0] : in_a[0];
    assign b_bit   = busy ? b_sh[0] : b_eff[0];
    assign c_in    = busy ? carry : sub;
    assign sum_bit = a_bit ^ b_bit ^ c_in;
    assign c_out   = (a_bit & b_bit) | (c_in & (a_bit ^ b_bit));

    always_ff @(posedge clk or posedge nRST) begin
        if (nRST) begin
            busy    <= 1'b0;
            finish  <= 1'b0;
            bit_cnt <= '0;
        end else begin
            finish <= 1'b0;
            if (load) begin
                busy    <= 1'b1;
                bit_cnt <= CNT_W'(1);                    // Bit 0 done on this edge
            end else if (busy) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (last_bit) begin
                    busy   <= 1'b0;
                    finish <= 1'b1;
                end
            end
        end
    end

    // Serial datapath, sum bits enter at the top and walk down
    always_ff @(posedge clk or posedge nRST) begin
        if (nRST) begin
            a_sh   <= '0;
            b_sh   <= '0;
            carry  <= 1'b0;
            result <= '0;
        end else begin
            if (load) begin
                a_sh <= in_a >> 1;
                b_sh <= b_eff >> 1;
            end else if (busy) begin
                a_sh <= a_sh >> 1;
                b_sh <= b_sh >> 1;
            end
            if (load || busy) begin
                carry  <= c_out;
                result <= {sum_bit, result[DATA_WIDTH-1:1]};
            end
        end
    end

endmodule

/* hdl/calc_controller.sv */
module calc_controller #(
    parameter int DATA_WIDTH = 16
) (
    input  logic                  clk,
    input  logic                  nRST,
    input  logic                  calc_go,               // Operands ready from entry
    input  calc_pkg::calc_op_t    op,
    input  logic [DATA_WIDTH-1:0] operand_a,
    input  logic [DATA_WIDTH-1:0] operand_b,
    input  logic [DATA_WIDTH-1:0] addsub_result,
    input  logic                  addsub_finish,
    input  logic [DATA_WIDTH-1:0] mul_result,
    input  logic                  mul_finish,
    output logic [DATA_WIDTH-1:0] unit_a,                // Shared operand bus
    output logic [DATA_WIDTH-1:0] unit_b,
    output logic                  sub,                   // Adder mode, high for OP_SUB
    output logic                  addsub_start,
    output logic                  mul_start,
    output logic                  entry_clear,           // Releases key entry
    output logic                  complete,              // New result flag
    output logic [DATA_WIDTH-1:0] display_output
);
    import calc_pkg::*;

    ctrl_state_t           state;
    logic                  use_mul;                      // Multiplier owns this operation
    logic                  dispatch;
    logic [DATA_WIDTH-1:0] unit_result;

    assign dispatch = (state == IDLE) && calc_go;

    // Pick the result of the unit that ran
    assign unit_result = use_mul ? mul_result : addsub_result;

    always_ff @(posedge clk or posedge nRST) begin
        if (nRST) begin
            state          <= IDLE;
            use_mul        <= 1'b0;
            sub            <= 1'b0;
            addsub_start   <= 1'b0;
            mul_start      <= 1'b0;
            entry_clear    <= 1'b0;
            complete       <= 1'b0;
            display_output <= '0;
        end else begin
            addsub_start <= 1'b0;                        // All strobes are one cycle
            mul_start    <= 1'b0;
            entry_clear  <= 1'b0;
            complete     <= 1'b0;
            case (state)
                IDLE: begin
                    if (calc_go) begin
                        case (op)
                            OP_MUL: begin
                                use_mul   <= 1'b1;
                                sub       <= 1'b0;
                                mul_start <= 1'b1;
                                state     <= RUN_MUL;
                            end
                            OP_SUB: begin
                                use_mul      <= 1'b0;
                                sub          <= 1'b1;
                                addsub_start <= 1'b1;
                                state        <= RUN_ADDSUB;
                            end
                            default: begin               // OP_ADD
                                use_mul      <= 1'b0;
                                sub          <= 1'b0;
                                addsub_start <= 1'b1;
                                state        <= RUN_ADDSUB;
                            end
                        endcase
                    end
                end
                RUN_ADDSUB: begin
                    if (addsub_finish) begin
                        state <= SHOW;
                    end
                end
                RUN_MUL: begin
                    if (mul_finish) begin
                        state <= SHOW;
                    end
                end
                SHOW: begin
                    display_output <= unit_result;       // Held until next SHOW
                    complete       <= 1'b1;
                    entry_clear    <= 1'b1;
                    state          <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Operands are captured once and stay put while a unit runs
    always_ff @(posedge clk or posedge nRST) begin
        if (nRST) begin
            unit_a <= '0;
            unit_b <= '0;
        end else if (dispatch) begin
            unit_a <= operand_a;
            unit_b <= operand_b;
        end
    end

endmodule

/* hdl/calc_pkg.sv */
package calc_pkg;

    // Keypad digit width, legal digits are 0 to 9
    localparam int KEY_WIDTH = 4;
    localparam logic [KEY_WIDTH-1:0] DIGIT_MAX = 4'd9;  // Largest accepted digit

    // Operator key codes
    typedef enum logic [2:0] {
        OP_NONE = 3'd0,                                  // No operator key
        OP_ADD  = 3'd1,
        OP_SUB  = 3'd2,
        OP_MUL  = 3'd3
    } calc_op_t;

    // Key entry FSM
    typedef enum logic [1:0] {
        ENTER_FIRST  = 2'd0,                             // Building operand A
        ENTER_SECOND = 2'd1,                             // Building operand B
        WAIT_RESULT  = 2'd2                              // Keys dropped here
    } entry_state_t;

    // Controller FSM
    typedef enum logic [1:0] {
        IDLE       = 2'd0,
        RUN_ADDSUB = 2'd1,                               // Serial adder busy
        RUN_MUL    = 2'd2,                               // Multiplier busy
        SHOW       = 2'd3                                // Result to display
    } ctrl_state_t;

    // Codes 4 to 7 count as no key
    function automatic logic op_is_valid(input calc_op_t code);
        return (code == OP_ADD) || (code == OP_SUB) || (code == OP_MUL);
    endfunction

endpackage

/* hdl/calc_top.sv */
module calc_top #(
    parameter int DATA_WIDTH = 16
) (
    input  logic                           clk,
    input  logic                           nRST,
    input  logic                           key_press,
    input  logic [calc_pkg::KEY_WIDTH-1:0] keypad_digit,
    input  calc_pkg::calc_op_t             operator_key,
    input  logic                           equal_key,
    output logic                           complete,
    output logic [DATA_WIDTH-1:0]          display_output
);
    import calc_pkg::*;

    // Entry to controller
    logic [DATA_WIDTH-1:0] operand_a;
    logic [DATA_WIDTH-1:0] operand_b;
    calc_op_t              op;
    logic                  calc_go;
    logic                  entry_clear;

    // Controller to units
    logic [DATA_WIDTH-1:0] unit_a;
    logic [DATA_WIDTH-1:0] unit_b;
    logic                  sub;
    logic                  addsub_start;
    logic                  mul_start;

    // Units back to controller
    logic [DATA_WIDTH-1:0] addsub_result;
    logic                  addsub_finish;
    logic [DATA_WIDTH-1:0] mul_result;
    logic                  mul_finish;

    key_entry #(.DATA_WIDTH(DATA_WIDTH)) key_entry_i (
        .clk          (clk),
        .nRST         (nRST),
        .key_press    (key_press),
        .keypad_digit (keypad_digit),
        .operator_key (operator_key),
        .equal_key    (equal_key),
        .entry_clear  (entry_clear),
        .operand_a    (operand_a),
        .operand_b    (operand_b),
        .op           (op),
        .calc_go      (calc_go)
    );

    addsub_unit #(.DATA_WIDTH(DATA_WIDTH)) addsub_unit_i (
        .clk    (clk),
        .nRST   (nRST),
        .start  (addsub_start),
        .sub    (sub),
        .in_a   (unit_a),
        .in_b   (unit_b),
        .result (addsub_result),
        .finish (addsub_finish)
    );

    shift_add_multiplier #(.DATA_WIDTH(DATA_WIDTH)) shift_add_multiplier_i (
        .clk    (clk),
        .nRST   (nRST),
        .start  (mul_start),
        .in_a   (unit_a),
        .in_b   (unit_b),
        .result (mul_result),
        .finish (mul_finish)
    );

    calc_controller #(.DATA_WIDTH(DATA_WIDTH)) calc_controller_i (
        .clk            (clk),
        .nRST           (nRST),
        .calc_go        (calc_go),
        .op             (op),
        .operand_a      (operand_a),
        .operand_b      (operand_b),
        .addsub_result  (addsub_result),
        .addsub_finish  (addsub_finish),
        .mul_result     (mul_result),
        .mul_finish     (mul_finish),
        .unit_a         (unit_a),
        .unit_b         (unit_b),
        .sub            (sub),
        .addsub_start   (addsub_start),
        .mul_start      (mul_start),
        .entry_clear    (entry_clear),
        .complete       (complete),
        .display_output (display_output)
    );

endmodule

/* hdl/key_entry.sv */
module key_entry #(
    parameter int DATA_WIDTH = 16
) (
    input  logic                           clk,
    input  logic                           nRST,
    input  logic                           key_press,     // Digit strobe
    input  logic [calc_pkg::KEY_WIDTH-1:0] keypad_digit,
    input  calc_pkg::calc_op_t             operator_key,
    input  logic                           equal_key,
    input  logic                           entry_clear,   // From controller
    output logic [DATA_WIDTH-1:0]          operand_a,
    output logic [DATA_WIDTH-1:0]          operand_b,
    output calc_pkg::calc_op_t             op,
    output logic                           calc_go        // Operands ready pulse
);
    import calc_pkg::*;

    entry_state_t state;
    logic         digit_ok;                              // Legal decimal key press

    // value * 10 + digit, as (value << 3) + (value << 1)
    function automatic logic [DATA_WIDTH-1:0] shift_in_digit(
        input logic [DATA_WIDTH-1:0] value,
        input logic [KEY_WIDTH-1:0]  digit
    );
        return (value << 3) + (value << 1) + DATA_WIDTH'(digit);
    endfunction

    assign digit_ok = key_press && (keypad_digit <= DIGIT_MAX);

    always_ff @(posedge clk or posedge nRST) begin
        if (nRST) begin
            state     <= ENTER_FIRST;
            operand_a <= '0;
            operand_b <= '0;
            op        <= OP_NONE;
            calc_go   <= 1'b0;
        end else begin
            calc_go <= 1'b0;                             // Pulse by default
            if (entry_clear) begin                       // Result shown, start over
                state     <= ENTER_FIRST;
                operand_a <= '0;
                operand_b <= '0;
                op        <= OP_NONE;
            end else begin
                case (state)
                    ENTER_FIRST: begin
                        if (digit_ok) begin
                            operand_a <= shift_in_digit(operand_a, keypad_digit);
                        end else if (op_is_valid(operator_key)) begin
                            op    <= operator_key;       // Latch operator
                            state <= ENTER_SECOND;
                        end
                    end
                    ENTER_SECOND: begin
                        if (digit_ok) begin
                            operand_b <= shift_in_digit(operand_b, keypad_digit);
                        end else if (equal_key) begin
                            calc_go <= 1'b1;             // Hand off to controller
                            state   <= WAIT_RESULT;
                        end
                    end
                    WAIT_RESULT: begin
                        state <= WAIT_RESULT;            // Hold until entry_clear
                    end
                    default: begin
                        state <= ENTER_FIRST;
                    end
                endcase
            end
        end
    end

endmodule

/* hdl/shift_add_multiplier.sv */
module shift_add_multiplier #(
    parameter int DATA_WIDTH = 16
) (
    input  logic                  clk,
    input  logic                  nRST,
    input  logic                  start,                 // Ignored while busy
    input  logic [DATA_WIDTH-1:0] in_a,                  // Multiplicand
    input  logic [DATA_WIDTH-1:0] in_b,                  // Multiplier
    output logic [DATA_WIDTH-1:0] result,                // Low half of product
    output logic                  finish
);
    localparam int CNT_W = (DATA_WIDTH > 1) ? $clog2(DATA_WIDTH) : 1;

    logic                  busy;
    logic [CNT_W-1:0]      step_cnt;                     // Multiplier bit in flight
    logic                  load;
    logic                  last_step;
    logic [DATA_WIDTH-1:0] mcand;                        // Multiplicand, shifted left
    logic [DATA_WIDTH-1:0] mplier;                       // Multiplier, shifted right
    logic [DATA_WIDTH-1:0] cur_mcand;
    logic [DATA_WIDTH-1:0] cur_mplier;
    logic [DATA_WIDTH-1:0] cur_acc;
    logic [DATA_WIDTH-1:0] acc_next;

    assign load      = start && !busy;
    assign last_step = (step_cnt == CNT_W'(DATA_WIDTH - 1));

    // Start edge handles bit 0 from the inputs with an empty accumulator
    assign cur_mcand  = busy ? mcand : in_a;
    assign cur_mplier = busy ? mplier : in_b;
    assign cur_acc    = busy ? result : '0;
    assign acc_next   = cur_mplier[0] ? (cur_acc + cur_mcand) : cur_acc;  // Wraps

    always_ff @(posedge clk or posedge nRST) begin
        if (nRST) begin
            busy     <= 1'b0;
            finish   <= 1'b0;
            step_cnt <= '0;
        end else begin
            finish <= 1'b0;
            if (load) begin
                busy     <= 1'b1;
                step_cnt <= CNT_W'(1);
            end else if (busy) begin
                step_cnt <= step_cnt + 1'b1;
                if (last_step) begin                     // Top multiplier bit added
                    busy   <= 1'b0;
                    finish <= 1'b1;
                end
            end
        end
    end

    // Accumulator doubles as the result register
    always_ff @(posedge clk or posedge nRST) begin
        if (nRST) begin
            result <= '0;
            mcand  <= '0;
            mplier <= '0;
        end else if (load || busy) begin
            result <= acc_next;
            mcand  <= cur_mcand << 1;
            mplier <= cur_mplier >> 1;
        end
    end

endmodule

/* tests/calc_top_tb.sv */
module calc_top_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import calc_pkg::*;

    localparam int DATA_WIDTH = 16;
    localparam int NUM_FIXED  = 8;
    localparam int NUM_CASES  = 16;                      // Fixed rows, then LCG rows
    localparam int TIMEOUT    = 100;                     // Cycles per wait

    logic                  clk;
    logic                  nRST;
    logic                  key_press;
    logic [KEY_WIDTH-1:0]  keypad_digit;
    calc_op_t              operator_key;
    logic                  equal_key;
    logic                  complete;
    logic [DATA_WIDTH-1:0] display_output;

    // Case table, digits kept as text so long entries can wrap
    string                 name_tbl[NUM_CASES];
    string                 a_tbl[NUM_CASES];
    calc_op_t              op_tbl[NUM_CASES];
    string                 b_tbl[NUM_CASES];
    logic [DATA_WIDTH-1:0] exp_tbl[NUM_CASES];

    int                    errors;
    int                    checks;
    logic [31:0]           lcg_state;
    logic [DATA_WIDTH-1:0] last_display;                 // Value that must hold

    tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(2)) tb_clock_gen_i (.clk(clk), .nRST(nRST));

    calc_top #(.DATA_WIDTH(DATA_WIDTH)) calc_top_i (
        .clk(clk), .nRST(nRST), .key_press(key_press), .keypad_digit(keypad_digit),
        .operator_key(operator_key), .equal_key(equal_key), .complete(complete),
        .display_output(display_output)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Decimal text to operand, wrapping after every digit
    function automatic logic [DATA_WIDTH-1:0] entry_value(input string s);
        logic [31:0] acc;
        acc = 0;
        for (int i = 0; i < s.len(); i++) begin
            acc = (acc * 10 + (int'(s[i]) - 48)) & 32'h0000_ffff;  // 48 is ASCII zero
        end
        return acc[DATA_WIDTH-1:0];
    endfunction

    function automatic logic [DATA_WIDTH-1:0] apply_op(input logic [DATA_WIDTH-1:0] a,
                                                       input calc_op_t code,
                                                       input logic [DATA_WIDTH-1:0] b);
        logic [31:0] prod;
        prod = a * b;                                    // Full 32-bit product
        case (code)
            OP_SUB:  return a - b;                       // Wraps mod 2^16
            OP_MUL:  return prod[DATA_WIDTH-1:0];
            default: return a + b;
        endcase
    endfunction

    task automatic set_row(input int i, input string name, input string a, input calc_op_t code,
                           input string b, input logic [DATA_WIDTH-1:0] expected);
        name_tbl[i] = name;
        a_tbl[i]    = a;
        op_tbl[i]   = code;
        b_tbl[i]    = b;
        exp_tbl[i]  = expected;
    endtask

    task automatic fill_table();
        logic [DATA_WIDTH-1:0] a;
        logic [DATA_WIDTH-1:0] b;
        calc_op_t              code;
        set_row(0, "add_zero_digits", "1050", OP_ADD, "2008", 16'd3058);
        set_row(1, "add_wrap", "65000", OP_ADD, "1000", 16'd464);
        set_row(2, "sub_basic", "5000", OP_SUB, "1234", 16'd3766);
        set_row(3, "sub_b_greater", "100", OP_SUB, "300", 16'd65336);
        set_row(4, "mul_basic", "123", OP_MUL, "45", 16'd5535);
        set_row(5, "mul_overflow", "300", OP_MUL, "300", 16'd24464);
        set_row(6, "long_digits_a", "1234567", OP_ADD, "1", 16'd54920);  // A wraps to 54919
        set_row(7, "long_digits_b", "7", OP_MUL, "99999", 16'd44633);    // B wraps to 34463
        for (int i = NUM_FIXED; i < NUM_CASES; i++) begin
            lcg_state = lcg_next(lcg_state);
            a         = lcg_state[31:16];
            lcg_state = lcg_next(lcg_state);
            b         = lcg_state[31:16];
            lcg_state = lcg_next(lcg_state);
            case (lcg_state[31:16] % 3)
                0:       code = OP_ADD;
                1:       code = OP_SUB;
                default: code = OP_MUL;
            endcase
            set_row(i, $sformatf("lcg_%0d", i), $sformatf("%0d", a), code,
                    $sformatf("%0d", b), 16'd0);
            exp_tbl[i] = apply_op(entry_value(a_tbl[i]), code, entry_value(b_tbl[i]));
        end
    endtask

    // Every key is a one-cycle pulse 1 ns after the edge
    task automatic press_digit(input int d);
        @(posedge clk);
        #1 key_press = 1'b1;
        keypad_digit = d[KEY_WIDTH-1:0];
        @(posedge clk);
        #1 key_press = 1'b0;
        keypad_digit = '0;
    endtask

    task automatic press_operator(input calc_op_t code);
        @(posedge clk);
        #1 operator_key = code;
        @(posedge clk);
        #1 operator_key = OP_NONE;
    endtask

    task automatic press_equal();
        @(posedge clk);
        #1 equal_key = 1'b1;
        @(posedge clk);
        #1 equal_key = 1'b0;
    endtask

    task automatic type_number(input string s);
        for (int i = 0; i < s.len(); i++) begin
            press_digit(int'(s[i]) - 48);
        end
    endtask

    task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] expected,
                               input logic [DATA_WIDTH-1:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("Error: %s expected %0d actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    // Display must hold the old value until complete
    task automatic wait_complete(input string name, output bit seen);
        int cnt;
        seen = 1'b0;
        for (cnt = 0; cnt < TIMEOUT && !seen; cnt++) begin
            @(negedge clk);
            if (complete) begin
                seen = 1'b1;
            end else begin
                check_value({name, "_hold"}, last_display, display_output);
            end
        end
        if (!seen) begin
            $display("Timeout in %s: complete did not rise within %0d cycles", name, TIMEOUT);
            errors++;
        end
    endtask

    task automatic run_case(input int i);
        bit seen;
        type_number(a_tbl[i]);
        press_operator(op_tbl[i]);
        type_number(b_tbl[i]);
        press_equal();
        press_digit(9);                                  // Dropped in WAIT_RESULT
        press_operator(OP_SUB);
        press_digit(4);
        press_equal();
        wait_complete(name_tbl[i], seen);
        if (seen) begin
            check_value(name_tbl[i], exp_tbl[i], display_output);
            last_display = exp_tbl[i];
            @(negedge clk);
            checks++;
            assert (complete === 1'b0) else begin
                $display("Complete stayed high for more than one cycle in %s", name_tbl[i]);
                errors++;
            end
            check_value({name_tbl[i], "_after"}, last_display, display_output);
        end
    endtask

    initial begin
        int cnt;
        key_press    = 1'b0;
        keypad_digit = '0;
        operator_key = OP_NONE;
        equal_key    = 1'b0;
        errors       = 0;
        checks       = 0;
        lcg_state    = 32'he81e;
        last_display = '0;
        fill_table();
        for (cnt = 0; cnt < TIMEOUT && nRST !== 1'b0; cnt++) begin
            @(posedge clk);
        end
        if (nRST !== 1'b0) begin
            $display("Reset was never released");
            errors++;
        end
        @(negedge clk);
        check_value("reset_complete", '0, {{(DATA_WIDTH-1){1'b0}}, complete});
        check_value("reset_display", '0, display_output);
        for (int i = 0; i < NUM_CASES; i++) begin
            run_case(i);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* tests/tb_clock_gen.sv */
module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic nRST
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;             // Free-running clock
    end

    initial begin
        nRST = 1'b1;                                     // Active high reset
        repeat (RESET_CYCLES) @(posedge clk);
        #1 nRST = 1'b0;
    end

endmodule
